//--- logic/i2c_pkg.sv
package i2c_pkg;

	localparam int byte_w     = 8;	// bits per i2c byte
	localparam int dev_addr_w = 7;	// 7-bit slave address

	// host operations
	typedef enum logic [1:0] {
		op_write        = 2'd0,
		op_read_current = 2'd1,
		op_read_random  = 2'd2
	} i2c_op_t;

	// commands from sequencer to bit engine
	typedef enum logic [1:0] {
		bc_start = 2'd0,	// start or repeated start
		bc_write = 2'd1,	// 8 bits out, sample ack
		bc_read  = 2'd2,	// 8 bits in, send nack
		bc_stop  = 2'd3
	} bit_cmd_t;

	// transaction phases
	typedef enum logic [3:0] {
		s_idle    = 4'd0,
		s_start   = 4'd1,
		s_dev_w   = 4'd2,
		s_word    = 4'd3,
		s_data    = 4'd4,
		s_restart = 4'd5,
		s_dev_r   = 4'd6,
		s_read    = 4'd7,
		s_stop    = 4'd8
	} seq_state_t;

endpackage

//--- logic/i2c_cmd_latch.sv
`timescale 1ns/1ps

module i2c_cmd_latch (
	input  logic                            clk,
	input  logic                            n_rst,
	input  logic                            go,
	input  i2c_pkg::i2c_op_t                op,
	input  logic [i2c_pkg::dev_addr_w-1:0]  dev_addr,
	input  logic [i2c_pkg::byte_w-1:0]      word_addr,
	input  logic [i2c_pkg::byte_w-1:0]      wdata,
	input  logic                            txn_done,
	input  logic                            nack_seen,
	input  logic                            rx_valid,
	input  logic [i2c_pkg::byte_w-1:0]      rx_byte,
	output logic                            txn_start,
	output i2c_pkg::i2c_op_t                op_q,
	output logic [i2c_pkg::dev_addr_w-1:0]  dev_addr_q,
	output logic [i2c_pkg::byte_w-1:0]      word_addr_q,
	output logic [i2c_pkg::byte_w-1:0]      wdata_q,
	output logic                            busy,
	output logic                            done,
	output logic                            ack_error,
	output logic                            data_ready,
	output logic [i2c_pkg::byte_w-1:0]      rdata
);

	logic go_q;	// go level one clock back
	logic accept;
	logic is_read;

	assign accept  = go & ~go_q & ~busy;	// edge while busy is dropped
	assign is_read = (op_q != i2c_pkg::op_write);

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			go_q <= 1'b0;
		end else begin
			go_q <= go;
		end
	end

	// status flags
	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			txn_start  <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			ack_error  <= 1'b0;
			data_ready <= 1'b0;
		end else begin
			txn_start <= accept;
			if (accept) begin
				busy       <= 1'b1;
				done       <= 1'b0;
				ack_error  <= 1'b0;
				data_ready <= 1'b0;
			end else begin
				if (nack_seen) begin
					ack_error <= 1'b1;
				end
				if (txn_done) begin
					busy       <= 1'b0;
					done       <= 1'b1;
					data_ready <= is_read & ~ack_error & ~nack_seen;	// only a clean read
				end
			end
		end
	end

	// command fields held for the whole transaction
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q        <= op;
			dev_addr_q  <= dev_addr;
			word_addr_q <= word_addr;
			wdata_q     <= wdata;
		end
		if (rx_valid) begin
			rdata <= rx_byte;
		end
	end

	// sequencer only ends a transaction that was opened
	a_done_in_txn: assert property (@(posedge clk) disable iff (!n_rst)
		txn_done |-> busy)
		else $error("txn_done with no transaction open");

endmodule

//--- logic/i2c_sequencer.sv
`timescale 1ns/1ps

module i2c_sequencer (
	input  logic                            clk,
	input  logic                            n_rst,
	input  logic                            txn_start,
	input  i2c_pkg::i2c_op_t                op_q,
	input  logic [i2c_pkg::dev_addr_w-1:0]  dev_addr_q,
	input  logic [i2c_pkg::byte_w-1:0]      word_addr_q,
	input  logic [i2c_pkg::byte_w-1:0]      wdata_q,
	input  logic                            bit_done,
	input  logic                            rx_ack,
	input  logic [i2c_pkg::byte_w-1:0]      rx_byte,
	output logic                            bit_req,
	output i2c_pkg::bit_cmd_t               bit_cmd,
	output logic [i2c_pkg::byte_w-1:0]      tx_byte,
	output logic                            txn_done,
	output logic                            nack_seen,
	output logic                            rx_valid
);

	i2c_pkg::seq_state_t state;
	i2c_pkg::seq_state_t state_nxt;
	logic                launch;		// first cycle of a phase
	logic                outstanding;	// a command sits in the bit engine
	logic                wr_phase;

	assign bit_req = launch;

	assign wr_phase = (state == i2c_pkg::s_dev_w) || (state == i2c_pkg::s_word) ||
		(state == i2c_pkg::s_data) || (state == i2c_pkg::s_dev_r);

	assign nack_seen = bit_done & wr_phase & ~rx_ack;
	assign rx_valid  = bit_done & (state == i2c_pkg::s_read);
	assign txn_done  = bit_done & (state == i2c_pkg::s_stop);

	// command and byte for the current phase
	always_comb begin
		tx_byte = {i2c_pkg::byte_w{1'b1}};
		case (state)
			i2c_pkg::s_start,
			i2c_pkg::s_restart: bit_cmd = i2c_pkg::bc_start;
			i2c_pkg::s_dev_w: begin
				bit_cmd = i2c_pkg::bc_write;
				tx_byte = {dev_addr_q, 1'b0};	// write direction
			end
			i2c_pkg::s_word: begin
				bit_cmd = i2c_pkg::bc_write;
				tx_byte = word_addr_q;
			end
			i2c_pkg::s_data: begin
				bit_cmd = i2c_pkg::bc_write;
				tx_byte = wdata_q;
			end
			i2c_pkg::s_dev_r: begin
				bit_cmd = i2c_pkg::bc_write;
				tx_byte = {dev_addr_q, 1'b1};	// read direction
			end
			i2c_pkg::s_read: bit_cmd = i2c_pkg::bc_read;
			default: bit_cmd = i2c_pkg::bc_stop;
		endcase
	end

	// phase order per operation
	always_comb begin
		state_nxt = state;
		case (state)
			i2c_pkg::s_start: begin
				if (op_q == i2c_pkg::op_read_current) begin
					state_nxt = i2c_pkg::s_dev_r;
				end else begin
					state_nxt = i2c_pkg::s_dev_w;
				end
			end
			i2c_pkg::s_dev_w: state_nxt = rx_ack ? i2c_pkg::s_word : i2c_pkg::s_stop;
			i2c_pkg::s_word: begin
				if (!rx_ack) begin
					state_nxt = i2c_pkg::s_stop;
				end else if (op_q == i2c_pkg::op_write) begin
					state_nxt = i2c_pkg::s_data;
				end else begin
					state_nxt = i2c_pkg::s_restart;	// dummy write done
				end
			end
			i2c_pkg::s_data:    state_nxt = i2c_pkg::s_stop;
			i2c_pkg::s_restart: state_nxt = i2c_pkg::s_dev_r;
			i2c_pkg::s_dev_r:   state_nxt = rx_ack ? i2c_pkg::s_read : i2c_pkg::s_stop;
			i2c_pkg::s_read:    state_nxt = i2c_pkg::s_stop;
			default:            state_nxt = i2c_pkg::s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			state       <= i2c_pkg::s_idle;
			launch      <= 1'b0;
			outstanding <= 1'b0;
		end else begin
			launch <= 1'b0;
			if (bit_req) begin
				outstanding <= 1'b1;
			end else if (bit_done) begin
				outstanding <= 1'b0;
			end
			if (state == i2c_pkg::s_idle) begin
				if (txn_start) begin
					state  <= i2c_pkg::s_start;
					launch <= 1'b1;
				end
			end else if (bit_done) begin
				state  <= state_nxt;
				launch <= (state_nxt != i2c_pkg::s_idle);
			end
		end
	end

	// one command in flight at a time
	a_no_overlap: assert property (@(posedge clk) disable iff (!n_rst)
		bit_req |-> !outstanding)
		else $error("bit_req issued before bit_done");

	a_rx_known: assert property (@(posedge clk) disable iff (!n_rst)
		rx_valid |-> !$isunknown(rx_byte))
		else $error("read byte unknown at rx_valid");

endmodule

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
	parameter int clk_div = 10
) (
	input  logic                        clk,
	input  logic                        n_rst,
	input  logic                        bit_req,
	input  i2c_pkg::bit_cmd_t           bit_cmd,
	input  logic [i2c_pkg::byte_w-1:0]  tx_byte,
	output logic                        bit_done,
	output logic [i2c_pkg::byte_w-1:0]  rx_byte,
	output logic                        rx_ack,
	output logic                        scl,
	inout  wire                         sda
);

	localparam int cnt_w = $clog2(clk_div + 2);
	localparam int bc_w  = $clog2(i2c_pkg::byte_w + 1);
	localparam int half  = clk_div / 2;

	logic                       active;
	i2c_pkg::bit_cmd_t          cmd_q;
	logic [cnt_w-1:0]           cnt;	// clocks within a half period
	logic [bc_w-1:0]            bit_cnt;	// slot index, byte_w is the ack slot
	logic [i2c_pkg::byte_w-1:0] tx_sh;
	logic                       scl_q;
	logic                       sda_low;	// 1 pulls the line low
	logic                       mid;
	logic                       last;
	logic                       ack_slot;
	logic                       last_slot;
	logic                       sda_in;

	assign scl    = scl_q;
	assign sda    = sda_low ? 1'b0 : 1'bz;
	assign sda_in = (sda == 1'b1);

	assign mid       = (cnt == cnt_w'(half));
	assign last      = (cnt == cnt_w'(clk_div));
	assign ack_slot  = (bit_cnt == bc_w'(i2c_pkg::byte_w));
	assign last_slot = (cmd_q == i2c_pkg::bc_start) || (cmd_q == i2c_pkg::bc_stop) || ack_slot;

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			active   <= 1'b0;
			cnt      <= '0;
			bit_cnt  <= '0;
			scl_q    <= 1'b1;	// bus idle
			sda_low  <= 1'b0;
			bit_done <= 1'b0;
		end else begin
			bit_done <= 1'b0;
			if (!active) begin
				if (bit_req) begin
					active  <= 1'b1;
					cnt     <= '0;
					bit_cnt <= '0;
					scl_q   <= 1'b0;	// each slot opens with scl low
				end
			end else begin
				cnt <= last ? '0 : cnt + 1'b1;
				if (!scl_q) begin
					// scl low half, data changes in the middle
					if (mid) begin
						case (cmd_q)
							i2c_pkg::bc_start: sda_low <= 1'b0;
							i2c_pkg::bc_stop:  sda_low <= 1'b1;
							i2c_pkg::bc_write: sda_low <= ack_slot ? 1'b0 : ~tx_sh[i2c_pkg::byte_w-1];
							default:           sda_low <= 1'b0;	// read bits and nack
						endcase
					end
					if (last) begin
						scl_q <= 1'b1;
					end
				end else begin
					// scl high half
					if (mid) begin
						case (cmd_q)
							i2c_pkg::bc_start: sda_low <= 1'b1;	// start condition
							i2c_pkg::bc_stop:  sda_low <= 1'b0;	// stop condition
							default:           sda_low <= sda_low;
						endcase
					end
					if (last) begin
						if (last_slot) begin
							active   <= 1'b0;
							bit_done <= 1'b1;
							scl_q    <= (cmd_q == i2c_pkg::bc_stop);	// hold low unless stopped
						end else begin
							scl_q   <= 1'b0;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
			end
		end
	end

	// shift and sample path
	always_ff @(posedge clk) begin
		if (!active && bit_req) begin
			cmd_q <= bit_cmd;
			tx_sh <= tx_byte;
		end else if (active) begin
			if (scl_q && last && !ack_slot) begin
				tx_sh <= {tx_sh[i2c_pkg::byte_w-2:0], 1'b0};	// msb first
			end
			if (scl_q && mid) begin
				if (cmd_q == i2c_pkg::bc_write && ack_slot) begin
					rx_ack <= ~sda_in;
				end
				if (cmd_q == i2c_pkg::bc_read && !ack_slot) begin
					rx_byte <= {rx_byte[i2c_pkg::byte_w-2:0], sda_in};
				end
			end
		end
	end

	// bus data may only move with scl high for start and stop
	a_sda_stable: assert property (@(posedge clk) disable iff (!n_rst)
		(scl_q && $past(scl_q) && $changed(sda_in)) |->
			(cmd_q == i2c_pkg::bc_start || cmd_q == i2c_pkg::bc_stop))
		else $error("sda moved while scl high");

endmodule

//--- logic/i2c_eeprom_master.sv
`timescale 1ns/1ps

module i2c_eeprom_master #(
	parameter int clk_div = 10	// scl half period minus one, in clk cycles
) (
	input  logic                            clk,
	input  logic                            n_rst,
	input  logic                            go,
	input  i2c_pkg::i2c_op_t                op,
	input  logic [i2c_pkg::dev_addr_w-1:0]  dev_addr,
	input  logic [i2c_pkg::byte_w-1:0]      word_addr,
	input  logic [i2c_pkg::byte_w-1:0]      wdata,
	output logic [i2c_pkg::byte_w-1:0]      rdata,
	output logic                            busy,
	output logic                            done,
	output logic                            ack_error,
	output logic                            data_ready,
	output logic                            scl,
	inout  wire                             sda
);

	// latch to sequencer
	logic                           txn_start;
	i2c_pkg::i2c_op_t               op_q;
	logic [i2c_pkg::dev_addr_w-1:0] dev_addr_q;
	logic [i2c_pkg::byte_w-1:0]     word_addr_q;
	logic [i2c_pkg::byte_w-1:0]     wdata_q;
	logic                           txn_done;
	logic                           nack_seen;
	logic                           rx_valid;

	// sequencer to bit engine
	logic                           bit_req;
	i2c_pkg::bit_cmd_t              bit_cmd;
	logic [i2c_pkg::byte_w-1:0]     tx_byte;
	logic                           bit_done;
	logic [i2c_pkg::byte_w-1:0]     rx_byte;
	logic                           rx_ack;

	i2c_cmd_latch u_cmd_latch (
		.clk         (clk),
		.n_rst       (n_rst),
		.go          (go),
		.op          (op),
		.dev_addr    (dev_addr),
		.word_addr   (word_addr),
		.wdata       (wdata),
		.txn_done    (txn_done),
		.nack_seen   (nack_seen),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.txn_start   (txn_start),
		.op_q        (op_q),
		.dev_addr_q  (dev_addr_q),
		.word_addr_q (word_addr_q),
		.wdata_q     (wdata_q),
		.busy        (busy),
		.done        (done),
		.ack_error   (ack_error),
		.data_ready  (data_ready),
		.rdata       (rdata)
	);

	i2c_sequencer u_sequencer (
		.clk         (clk),
		.n_rst       (n_rst),
		.txn_start   (txn_start),
		.op_q        (op_q),
		.dev_addr_q  (dev_addr_q),
		.word_addr_q (word_addr_q),
		.wdata_q     (wdata_q),
		.bit_done    (bit_done),
		.rx_ack      (rx_ack),
		.rx_byte     (rx_byte),
		.bit_req     (bit_req),
		.bit_cmd     (bit_cmd),
		.tx_byte     (tx_byte),
		.txn_done    (txn_done),
		.nack_seen   (nack_seen),
		.rx_valid    (rx_valid)
	);

	i2c_bit_engine #(
		.clk_div (clk_div)
	) u_bit_engine (
		.clk      (clk),
		.n_rst    (n_rst),
		.bit_req  (bit_req),
		.bit_cmd  (bit_cmd),
		.tx_byte  (tx_byte),
		.bit_done (bit_done),
		.rx_byte  (rx_byte),
		.rx_ack   (rx_ack),
		.scl      (scl),
		.sda      (sda)
	);

endmodule

//--- bench/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model #(
	parameter logic [6:0] dev_addr = 7'h50
) (
	input  logic        scl,
	inout  wire         sda,
	output logic [15:0] wr_count	// data bytes stored so far
);

	typedef enum int {m_idle, m_dev, m_word, m_data, m_read} m_state_t;

	logic [7:0] mem [0:255];
	logic [7:0] ptr;	// address pointer
	logic [7:0] shift;
	logic [7:0] rd_byte;
	logic       drive_low;
	logic       master_ack;
	int         bit_cnt;	// scl rising edges in this byte, 9 after the ack slot
	m_state_t   state;
	m_state_t   after;		// phase that follows the ack slot

	assign sda = drive_low ? 1'b0 : 1'bz;
	pullup (sda);

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'h00;
		end
		ptr       = 8'h00;
		wr_count  = 16'd0;
		drive_low = 1'b0;
		bit_cnt   = 0;
		state     = m_idle;
		after     = m_idle;
	end

	// start and repeated start
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			state     = m_dev;
			bit_cnt   = 0;
			drive_low = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin
			state   = m_idle;	// stop
			bit_cnt = 0;
		end
	end

	always @(posedge scl) begin
		if (state != m_idle) begin
			if (bit_cnt < 8) begin
				shift = {shift[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
			end else if (bit_cnt == 8) begin
				master_ack = (sda === 1'b0);
			end
			bit_cnt = bit_cnt + 1;
		end
	end

	always @(negedge scl) begin
		if (state != m_idle) begin
			if (bit_cnt == 8) begin
				case (state)
					m_dev: begin
						if (shift[7:1] == dev_addr) begin
							drive_low = 1'b1;
							after     = shift[0] ? m_read : m_word;
						end else begin
							state = m_idle;	// not our address, no ack
						end
					end
					m_word: begin
						ptr       = shift;
						drive_low = 1'b1;
						after     = m_data;
					end
					m_data: begin
						mem[ptr]  = shift;
						ptr       = ptr + 8'd1;
						wr_count  = wr_count + 16'd1;
						drive_low = 1'b1;
						after     = m_data;
					end
					default: drive_low = 1'b0;	// master owns the ack slot
				endcase
			end else if (bit_cnt == 9) begin
				drive_low = 1'b0;
				bit_cnt   = 0;
				state     = (state == m_read && !master_ack) ? m_idle : after;
				if (state == m_read) begin
					rd_byte   = mem[ptr];
					ptr       = ptr + 8'd1;
					drive_low = ~rd_byte[7];
				end
			end else if (bit_cnt >= 1 && state == m_read) begin
				drive_low = ~rd_byte[7 - bit_cnt];	// next bit, msb first
			end
		end
	end

endmodule

//--- bench/tb_i2c_eeprom_master.sv
`timescale 1ns/1ps

module tb_i2c_eeprom_master;

	localparam int clk_div   = 10;
	localparam int slot_clks = 2 * (clk_div + 1);
	// 25 transfers of at most 40 bit slots each, rounded up to 30
	localparam int timeout_cycles = 30 * 40 * slot_clks;

	logic                            clk;
	logic                            n_rst;
	logic                            go;
	i2c_pkg::i2c_op_t                op;
	logic [i2c_pkg::dev_addr_w-1:0]  dev_addr;
	logic [i2c_pkg::byte_w-1:0]      word_addr;
	logic [i2c_pkg::byte_w-1:0]      wdata;
	logic [i2c_pkg::byte_w-1:0]      rdata;
	logic                            busy;
	logic                            done;
	logic                            ack_error;
	logic                            data_ready;
	logic                            scl;
	wire                             sda;
	logic [15:0]                     wr_count;
	int                              cycles;
	int                              errors;
	int                              tests_pass;
	int                              tests_fail;
	integer                          seed;

	i2c_eeprom_master #(
		.clk_div (clk_div)
	) u_dut (
		.clk        (clk),
		.n_rst      (n_rst),
		.go         (go),
		.op         (op),
		.dev_addr   (dev_addr),
		.word_addr  (word_addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.busy       (busy),
		.done       (done),
		.ack_error  (ack_error),
		.data_ready (data_ready),
		.scl        (scl),
		.sda        (sda)
	);

	eeprom_model #(
		.dev_addr (7'h50)
	) u_eeprom (
		.scl      (scl),
		.sda      (sda),
		.wr_count (wr_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("timeout: the run did not end within %0d clock cycles", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic close_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_pass++;
			$display("test %s: ok", name);
		end else begin
			tests_fail++;
			$display("test %s: %0d mismatches", name, errors - errs_before);
		end
	endtask

	// one go pulse, then wait for done
	task automatic run_txn(input i2c_pkg::i2c_op_t t_op, input logic [6:0] t_dev,
		input logic [7:0] t_word, input logic [7:0] t_data);
		@(negedge clk);
		op        = t_op;
		dev_addr  = t_dev;
		word_addr = t_word;
		wdata     = t_data;
		go        = 1'b1;
		@(negedge clk);
		go = 1'b0;
		check_eq("busy after go", busy, 1);
		check_eq("done after go", done, 0);
		while (!done) begin
			@(negedge clk);
		end
		check_eq("busy at done", busy, 0);
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		check_eq("busy", busy, 0);
		check_eq("done", done, 0);
		check_eq("ack_error", ack_error, 0);
		check_eq("data_ready", data_ready, 0);
		check_eq("scl idle", scl, 1);
		check_eq("sda idle", sda, 1);
		close_test("reset_state", e0);
	endtask

	task automatic test_write_read();
		int e0;
		e0 = errors;
		run_txn(i2c_pkg::op_write, 7'h50, 8'h3c, 8'ha5);
		check_eq("ack_error after write", ack_error, 0);
		check_eq("data_ready after write", data_ready, 0);
		run_txn(i2c_pkg::op_read_random, 7'h50, 8'h3c, 8'h00);
		check_eq("rdata at 3c", rdata, 8'ha5);
		check_eq("data_ready after read", data_ready, 1);
		check_eq("ack_error after read", ack_error, 0);
		close_test("write_read", e0);
	endtask

	task automatic test_current_read();
		int e0;
		e0 = errors;
		run_txn(i2c_pkg::op_write, 7'h50, 8'h90, 8'h11);
		run_txn(i2c_pkg::op_write, 7'h50, 8'h91, 8'h22);
		run_txn(i2c_pkg::op_read_random, 7'h50, 8'h90, 8'h00);
		check_eq("rdata at 90", rdata, 8'h11);
		run_txn(i2c_pkg::op_read_current, 7'h50, 8'h00, 8'h00);	// pointer now at 91
		check_eq("current read rdata", rdata, 8'h22);
		check_eq("data_ready after current read", data_ready, 1);
		close_test("current_read", e0);
	endtask

	task automatic test_nack();
		int          e0;
		logic [15:0] cnt0;
		e0   = errors;
		cnt0 = wr_count;
		run_txn(i2c_pkg::op_write, 7'h51, 8'h10, 8'h77);
		check_eq("done after nack", done, 1);
		check_eq("ack_error after nack", ack_error, 1);
		check_eq("data_ready after nack", data_ready, 0);
		check_eq("scl after nack", scl, 1);
		check_eq("sda after nack", sda, 1);
		check_eq("writes after nack", wr_count, cnt0);
		run_txn(i2c_pkg::op_read_current, 7'h51, 8'h00, 8'h00);	// nack on the read address
		check_eq("ack_error after read nack", ack_error, 1);
		check_eq("data_ready after read nack", data_ready, 0);
		close_test("nack", e0);
	endtask

	task automatic test_go_filter();
		int          e0;
		logic [15:0] cnt0;
		logic        extra;
		e0    = errors;
		cnt0  = wr_count;
		extra = 1'b0;
		@(negedge clk);
		op        = i2c_pkg::op_write;
		dev_addr  = 7'h50;
		word_addr = 8'h70;
		wdata     = 8'h5a;
		go        = 1'b1;
		@(negedge clk);
		go = 1'b0;
		check_eq("busy after go", busy, 1);
		repeat (20) @(negedge clk);
		go = 1'b1;	// edge while busy
		@(negedge clk);
		go = 1'b0;
		@(negedge clk);
		go = 1'b1;	// stays high across done
		while (!done) begin
			@(negedge clk);
		end
		repeat (40) begin
			@(negedge clk);
			if (busy) begin
				extra = 1'b1;
			end
		end
		go = 1'b0;
		check_eq("busy while go held", extra, 0);
		check_eq("done while go held", done, 1);
		check_eq("write count", wr_count, cnt0 + 16'd1);
		close_test("go_filter", e0);
	endtask

	task automatic test_random_pairs();
		int         e0;
		logic [7:0] addr;
		logic [7:0] data;
		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			addr = $random(seed);
			data = $random(seed);
			run_txn(i2c_pkg::op_write, 7'h50, addr, data);
			check_eq("ack_error on random write", ack_error, 0);
			run_txn(i2c_pkg::op_read_random, 7'h50, addr, 8'h00);
			check_eq("random read back", rdata, data);
			check_eq("data_ready on random read", data_ready, 1);
		end
		close_test("random_pairs", e0);
	endtask

	initial begin
		errors     = 0;
		tests_pass = 0;
		tests_fail = 0;
		seed       = 32'h876b;
		n_rst      = 1'b0;
		go         = 1'b0;
		op         = i2c_pkg::op_write;
		dev_addr   = '0;
		word_addr  = '0;
		wdata      = '0;
		repeat (10) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		test_reset_state();
		test_write_read();
		test_current_read();
		test_nack();
		test_go_filter();
		test_random_pairs();
		$display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
			tests_pass, tests_fail, errors);
		if (tests_fail == 0 && errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- i2c_eeprom_master.f
logic/i2c_pkg.sv
logic/i2c_cmd_latch.sv
logic/i2c_sequencer.sv
logic/i2c_bit_engine.sv
logic/i2c_eeprom_master.sv
bench/eeprom_model.sv
bench/tb_i2c_eeprom_master.sv

//--- Bender.yml
package:
  name: i2c_eeprom_master

sources:
  - files:
      - logic/i2c_pkg.sv
      - logic/i2c_cmd_latch.sv
      - logic/i2c_sequencer.sv
      - logic/i2c_bit_engine.sv
      - logic/i2c_eeprom_master.sv
  - target: test
    files:
      - bench/eeprom_model.sv
      - bench/tb_i2c_eeprom_master.sv
